// ==== source/raster_pkg.sv ====
package raster_pkg;

    localparam int COORD_W = 10;  // signed screen coordinate
    localparam int DEPTH_W = 12;  // unsigned depth, all ones is far
    localparam int CIDX_W  = 4;   // colour index into the palette

    localparam logic [DEPTH_W-1:0] DEPTH_FAR = '1;

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
    } vertex_t;

    // one flat-shaded triangle, z is taken from vertex 0
    typedef struct packed {
        vertex_t             v0;
        vertex_t             v1;
        vertex_t             v2;
        logic [DEPTH_W-1:0]  z;
        logic [CIDX_W-1:0]   cidx;
    } triangle_t;

    // framebuffer word, depth in the upper bits
    typedef struct packed {
        logic [DEPTH_W-1:0]  depth;
        logic [CIDX_W-1:0]   cidx;
    } fb_word_t;

    // 4-bit red, green, blue per entry
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa,
        12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff,
        12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

endpackage

// ==== source/tri_rasterizer.sv ====
`timescale 1ns/1ps

module tri_rasterizer #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic                                  clk_pix,
    input  logic                                  i_rst_n,
    input  logic                                  i_start,
    input  raster_pkg::triangle_t                 i_tri,
    input  logic                                  i_grant,
    output logic                                  o_req,
    output logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  o_addr,
    output logic [raster_pkg::DEPTH_W-1:0]        o_z,
    output logic [raster_pkg::CIDX_W-1:0]         o_cidx,
    output logic                                  o_busy,
    output logic                                  o_done
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(SCREEN_W * SCREEN_H);
    localparam int EDGE_W = 2 * COORD_W + 4;  // headroom for the edge products
    localparam logic signed [COORD_W-1:0] X_LAST = COORD_W'(SCREEN_W - 1);
    localparam logic signed [COORD_W-1:0] Y_LAST = COORD_W'(SCREEN_H - 1);

    typedef enum logic [1:0] {IDLE, SETUP, WALK} state_t;

    state_t                    state;
    triangle_t                 tri_q;
    vertex_t                   vtx [3];
    logic signed [COORD_W-1:0] lo_x, hi_x, lo_y, hi_y;
    logic signed [COORD_W-1:0] bx_min, bx_max, by_min, by_max;  // clipped box
    logic signed [COORD_W-1:0] x_min, x_max, y_max;
    logic signed [COORD_W-1:0] x, y;
    logic [ADDR_W-1:0]         addr_row;
    logic signed [EDGE_W-1:0]  da [3], db [3], e_init [3];
    logic signed [EDGE_W-1:0]  ea [3], eb [3], e [3], e_row [3];
    logic                      box_empty, in_tri, advance, last_col, last_row;

    function automatic logic signed [COORD_W-1:0] min3(input logic signed [COORD_W-1:0] a,
                                                       input logic signed [COORD_W-1:0] b,
                                                       input logic signed [COORD_W-1:0] c);
        logic signed [COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [COORD_W-1:0] max3(input logic signed [COORD_W-1:0] a,
                                                       input logic signed [COORD_W-1:0] b,
                                                       input logic signed [COORD_W-1:0] c);
        logic signed [COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // box and edge setup from the captured triangle
    always_comb begin
        vtx[0] = tri_q.v0;
        vtx[1] = tri_q.v1;
        vtx[2] = tri_q.v2;
        lo_x = min3(vtx[0].x, vtx[1].x, vtx[2].x);
        hi_x = max3(vtx[0].x, vtx[1].x, vtx[2].x);
        lo_y = min3(vtx[0].y, vtx[1].y, vtx[2].y);
        hi_y = max3(vtx[0].y, vtx[1].y, vtx[2].y);
        bx_min = (lo_x < 0) ? '0 : lo_x;
        bx_max = (hi_x > X_LAST) ? X_LAST : hi_x;
        by_min = (lo_y < 0) ? '0 : lo_y;
        by_max = (hi_y > Y_LAST) ? Y_LAST : hi_y;
        box_empty = (bx_min > bx_max) || (by_min > by_max);
        // edge k runs from vertex k to vertex k+1
        for (int k = 0; k < 3; k++) begin
            da[k] = vtx[(k + 1) % 3].y - vtx[k].y;  // step in x
            db[k] = vtx[k].x - vtx[(k + 1) % 3].x;  // step in y
            e_init[k] = (bx_min - vtx[k].x) * da[k] + (by_min - vtx[k].y) * db[k];
        end
    end

    // either winding counts as inside
    assign in_tri = (e[0] >= 0 && e[1] >= 0 && e[2] >= 0) ||
                    (e[0] <= 0 && e[1] <= 0 && e[2] <= 0);
    assign o_req    = (state == WALK) && in_tri;
    assign advance  = (state == WALK) && (!in_tri || i_grant);  // hold until granted
    assign last_col = (x == x_max);
    assign last_row = (y == y_max);
    assign o_busy   = (state != IDLE);
    assign o_z      = tri_q.z;
    assign o_cidx   = tri_q.cidx;

    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            state  <= IDLE;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) state <= SETUP;
                end
                SETUP: begin
                    state  <= box_empty ? IDLE : WALK;
                    o_done <= box_empty;  // nothing on screen
                end
                WALK: begin
                    if (advance && last_col && last_row) begin
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // walk datapath, edges stepped incrementally
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && i_start) tri_q <= i_tri;
        if (state == SETUP) begin
            x        <= bx_min;
            y        <= by_min;
            x_min    <= bx_min;
            x_max    <= bx_max;
            y_max    <= by_max;
            o_addr   <= ADDR_W'(by_min * SCREEN_W + bx_min);
            addr_row <= ADDR_W'(by_min * SCREEN_W + bx_min);
            for (int k = 0; k < 3; k++) begin
                ea[k]    <= da[k];
                eb[k]    <= db[k];
                e[k]     <= e_init[k];
                e_row[k] <= e_init[k];
            end
        end else if (advance) begin
            if (last_col) begin
                x        <= x_min;
                y        <= y + 1'b1;
                o_addr   <= addr_row + ADDR_W'(SCREEN_W);
                addr_row <= addr_row + ADDR_W'(SCREEN_W);
                for (int k = 0; k < 3; k++) begin
                    e[k]     <= e_row[k] + eb[k];
                    e_row[k] <= e_row[k] + eb[k];
                end
            end else begin
                x      <= x + 1'b1;
                o_addr <= o_addr + 1'b1;
                for (int k = 0; k < 3; k++) e[k] <= e[k] + ea[k];
            end
        end
    end

endmodule

// ==== source/fb_arbiter.sv ====
`timescale 1ns/1ps

module fb_arbiter #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic                                  clk_pix,
    input  logic                                  i_rst_n,
    input  logic                                  i_disp_req,
    input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  i_disp_addr,
    input  logic                                  i_rast_req,
    input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  i_rast_addr,
    input  logic                                  i_clearing,
    output logic                                  o_rast_grant,
    output logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  o_rd_addr,
    output logic                                  o_rast_data_valid
);

    // display has fixed priority, and the raster side is locked out
    // while the clear sweep owns the write port
    assign o_rast_grant = i_rast_req && !i_disp_req && !i_clearing;

    // display requests are never refused
    assign o_rd_addr = i_disp_req ? i_disp_addr : i_rast_addr;

    // owner of the word coming back next cycle
    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            o_rast_data_valid <= 1'b0;
        end else begin
            o_rast_data_valid <= o_rast_grant;  // depth test data
        end
    end

endmodule

// ==== source/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer #(
    parameter int SCREEN_W   = 160,
    parameter int SCREEN_H   = 120,
    parameter int CLEAR_CIDX = 10
) (
    input  logic                                  clk_pix,
    input  logic                                  i_rst_n,
    input  logic                                  i_clear,
    input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  i_rd_addr,
    input  logic                                  i_rast_valid,
    input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  i_wr_addr,
    input  logic [raster_pkg::DEPTH_W-1:0]        i_wr_z,
    input  logic [raster_pkg::CIDX_W-1:0]         i_wr_cidx,
    output raster_pkg::fb_word_t                  o_rd_data,
    output logic                                  o_clearing
);
    import raster_pkg::*;

    localparam int FB_DEPTH = SCREEN_W * SCREEN_H;
    localparam int ADDR_W   = $clog2(FB_DEPTH);

    fb_word_t           mem [FB_DEPTH];
    logic [ADDR_W-1:0]  clr_addr;
    logic [ADDR_W-1:0]  pix_addr, wr_addr;
    logic [DEPTH_W-1:0] pix_z;
    logic [CIDX_W-1:0]  pix_cidx;
    fb_word_t           wr_word;
    logic               wr_en;

    always_ff @(posedge clk_pix) begin
        o_rd_data <= mem[i_rd_addr];  // one cycle read latency
        pix_addr  <= i_wr_addr;       // pixel under test, lines up with read data
        pix_z     <= i_wr_z;
        pix_cidx  <= i_wr_cidx;
    end

    // clear sweep owns the write port while it runs
    always_comb begin
        if (o_clearing) begin
            wr_en   = 1'b1;
            wr_addr = clr_addr;
            wr_word = '{depth: DEPTH_FAR, cidx: CIDX_W'(CLEAR_CIDX)};
        end else begin
            wr_en   = i_rast_valid && (pix_z < o_rd_data.depth);  // strictly nearer
            wr_addr = pix_addr;
            wr_word = '{depth: pix_z, cidx: pix_cidx};
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wr_en) mem[wr_addr] <= wr_word;
    end

    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            o_clearing <= 1'b0;
            clr_addr   <= '0;
        end else if (o_clearing) begin
            o_clearing <= (clr_addr != ADDR_W'(FB_DEPTH - 1));
            clr_addr   <= clr_addr + 1'b1;
        end else if (i_clear) begin
            o_clearing <= 1'b1;
            clr_addr   <= '0;
        end
    end

endmodule

// ==== source/display_scan.sv ====
`timescale 1ns/1ps

module display_scan #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120,
    parameter int H_TOTAL  = 200,
    parameter int V_TOTAL  = 140
) (
    input  logic                                  clk_pix,
    input  logic                                  i_rst_n,
    output logic                                  o_req,
    output logic [$clog2(SCREEN_W*SCREEN_H)-1:0]  o_addr,
    input  raster_pkg::fb_word_t                  i_rd_data,
    output logic [raster_pkg::COORD_W-1:0]        o_sx,
    output logic [raster_pkg::COORD_W-1:0]        o_sy,
    output logic                                  o_de,
    output logic                                  o_frame,
    output logic [7:0]                            o_r,
    output logic [7:0]                            o_g,
    output logic [7:0]                            o_b
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(SCREEN_W * SCREEN_H);
    localparam int HW     = $clog2(H_TOTAL);
    localparam int VW     = $clog2(V_TOTAL);

    logic [HW-1:0] hc, hc_n, sx1;
    logic [VW-1:0] vc, vc_n, sy1;
    logic          de1, frame1;
    logic [11:0]   rgb;

    always_comb begin
        hc_n = hc + 1'b1;
        vc_n = vc;
        if (hc == HW'(H_TOTAL - 1)) begin
            hc_n = '0;
            vc_n = (vc == VW'(V_TOTAL - 1)) ? '0 : vc + 1'b1;
        end
    end

    // request is registered together with the position it belongs to
    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            hc    <= '0;
            vc    <= '0;
            o_req <= 1'b0;
        end else begin
            hc    <= hc_n;
            vc    <= vc_n;
            o_req <= (hc_n < SCREEN_W) && (vc_n < SCREEN_H);
        end
    end

    assign o_addr = ADDR_W'(vc * SCREEN_W + hc);
    assign rgb    = PALETTE[i_rd_data.cidx];

    // stage 1 waits on the memory, stage 2 on the palette
    always_ff @(posedge clk_pix) begin
        sx1  <= hc;
        sy1  <= vc;
        o_sx <= COORD_W'(sx1);
        o_sy <= COORD_W'(sy1);
        o_r  <= de1 ? {2{rgb[11:8]}} : 8'h00;  // nibble doubled
        o_g  <= de1 ? {2{rgb[7:4]}} : 8'h00;
        o_b  <= de1 ? {2{rgb[3:0]}} : 8'h00;
    end

    always_ff @(posedge clk_pix) begin
        if (!i_rst_n) begin
            de1     <= 1'b0;
            frame1  <= 1'b0;
            o_de    <= 1'b0;
            o_frame <= 1'b0;
        end else begin
            de1     <= o_req;
            frame1  <= o_req && (hc == '0) && (vc == '0);
            o_de    <= de1;
            o_frame <= frame1;
        end
    end

endmodule

// ==== source/raster_top.sv ====
`timescale 1ns/1ps

module raster_top #(
    parameter int SCREEN_W   = 160,
    parameter int SCREEN_H   = 120,
    parameter int H_TOTAL    = 200,
    parameter int V_TOTAL    = 140,
    parameter int CLEAR_CIDX = 10
) (
    input  logic                            clk_pix,
    input  logic                            i_rst_n,
    input  raster_pkg::triangle_t           i_tri,
    input  logic                            i_start,
    input  logic                            i_clear,
    output logic                            o_busy,
    output logic                            o_done,
    output logic                            o_clear_busy,
    output logic [raster_pkg::COORD_W-1:0]  o_sx,
    output logic [raster_pkg::COORD_W-1:0]  o_sy,
    output logic                            o_de,
    output logic [7:0]                      o_r,
    output logic [7:0]                      o_g,
    output logic [7:0]                      o_b,
    output logic                            o_frame
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(SCREEN_W * SCREEN_H);

    logic               disp_req, rast_req, rast_grant, rast_data_valid;
    logic [ADDR_W-1:0]  disp_addr, rast_addr, rd_addr;
    logic [DEPTH_W-1:0] rast_z;
    logic [CIDX_W-1:0]  rast_cidx;
    fb_word_t           rd_data;   // shared by both readers

    tri_rasterizer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_rast (
        .clk_pix (clk_pix),       .i_rst_n (i_rst_n),
        .i_start (i_start && !o_clear_busy),  // no start during a clear
        .i_tri   (i_tri),         .i_grant (rast_grant),
        .o_req   (rast_req),      .o_addr  (rast_addr),
        .o_z     (rast_z),        .o_cidx  (rast_cidx),
        .o_busy  (o_busy),        .o_done  (o_done)
    );

    fb_arbiter #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_arb (
        .clk_pix (clk_pix),       .i_rst_n     (i_rst_n),
        .i_disp_req  (disp_req),  .i_disp_addr (disp_addr),
        .i_rast_req  (rast_req),  .i_rast_addr (rast_addr),
        .i_clearing  (o_clear_busy),
        .o_rast_grant (rast_grant), .o_rd_addr (rd_addr),
        .o_rast_data_valid (rast_data_valid)
    );

    frame_buffer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .CLEAR_CIDX(CLEAR_CIDX)) u_fb (
        .clk_pix (clk_pix),       .i_rst_n (i_rst_n),
        .i_clear (i_clear),       .i_rd_addr (rd_addr),
        .i_rast_valid (rast_data_valid),
        .i_wr_addr (rast_addr),   .i_wr_z (rast_z),   .i_wr_cidx (rast_cidx),
        .o_rd_data (rd_data),     .o_clearing (o_clear_busy)
    );

    display_scan #(
        .SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)
    ) u_disp (
        .clk_pix (clk_pix),       .i_rst_n (i_rst_n),
        .o_req   (disp_req),      .o_addr  (disp_addr),
        .i_rd_data (rd_data),
        .o_sx (o_sx), .o_sy (o_sy), .o_de (o_de), .o_frame (o_frame),
        .o_r  (o_r),  .o_g  (o_g),  .o_b  (o_b)
    );

endmodule

// ==== sim/raster_assert.sv ====
`timescale 1ns/1ps

module raster_assert (
    input logic clk_pix,
    input logic i_rst_n,
    input logic i_disp_req,
    input logic i_rast_req,
    input logic i_clearing,
    input logic i_rast_grant
);

    // display always wins the read port
    a_disp_wins: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_rast_grant |-> !i_disp_req)
        else $error("raster grant while the display requests");

    a_clear_lockout: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_rast_grant |-> !i_clearing)
        else $error("raster grant during a clear sweep");

    a_grant_has_req: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
        i_rast_grant |-> i_rast_req)
        else $error("raster grant without a raster request");

endmodule

bind fb_arbiter raster_assert u_arb_assert (
    .clk_pix      (clk_pix),
    .i_rst_n      (i_rst_n),
    .i_disp_req   (i_disp_req),
    .i_rast_req   (i_rast_req),
    .i_clearing   (i_clearing),
    .i_rast_grant (o_rast_grant)
);

// ==== sim/tb_raster_top.sv ====
`timescale 1ns/1ps

module tb_raster_top;
    import raster_pkg::*;

    localparam int SW = 32;
    localparam int SH = 24;
    localparam int HT = 40;
    localparam int VT = 28;
    localparam int CLR_CIDX = 10;
    localparam int N_PIX = SW * SH;
    localparam int CLK_PERIOD = 8;
    localparam int N_TRI = 17;              // 1 single + 12 depth + 4 contention
    localparam int N_FRAMES = 3 * N_TRI + 12;
    localparam int WATCHDOG_CYCLES = N_TRI * N_PIX * 2 + N_FRAMES * HT * VT;

    logic                clk_pix = 1'b0;
    logic                i_rst_n;
    triangle_t           i_tri;
    logic                i_start, i_clear;
    logic                o_busy, o_done, o_clear_busy, o_de, o_frame;
    logic [COORD_W-1:0]  o_sx, o_sy;
    logic [7:0]          o_r, o_g, o_b;

    logic [DEPTH_W-1:0]  m_depth [N_PIX];   // reference framebuffer
    logic [CIDX_W-1:0]   m_cidx [N_PIX];
    logic [31:0]         lfsr_state = 32'h9fbbc66c;
    int                  value_errors = 0;
    int                  other_errors = 0;

    raster_top #(
        .SCREEN_W(SW), .SCREEN_H(SH), .H_TOTAL(HT), .V_TOTAL(VT), .CLEAR_CIDX(CLR_CIDX)
    ) dut (
        .clk_pix (clk_pix), .i_rst_n (i_rst_n), .i_tri (i_tri),
        .i_start (i_start), .i_clear (i_clear),
        .o_busy (o_busy), .o_done (o_done), .o_clear_busy (o_clear_busy),
        .o_sx (o_sx), .o_sy (o_sy), .o_de (o_de),
        .o_r (o_r), .o_g (o_g), .o_b (o_b), .o_frame (o_frame)
    );

    always #(CLK_PERIOD / 2) clk_pix = ~clk_pix;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // -4 .. span+3 puts some vertices off screen
    function automatic int rand_coord(input int span);
        return int'(rand_bits(8) % (span + 8)) - 4;
    endfunction

    function automatic triangle_t random_tri();
        triangle_t t;
        t.v0.x = COORD_W'(rand_coord(SW));
        t.v0.y = COORD_W'(rand_coord(SH));
        t.v1.x = COORD_W'(rand_coord(SW));
        t.v1.y = COORD_W'(rand_coord(SH));
        t.v2.x = COORD_W'(rand_coord(SW));
        t.v2.y = COORD_W'(rand_coord(SH));
        t.z    = DEPTH_W'(rand_bits(DEPTH_W));
        t.cidx = CIDX_W'(rand_bits(CIDX_W));
        return t;
    endfunction

    function automatic int edge_val(input vertex_t a, input vertex_t b, input int px,
                                    input int py);
        int ax, ay, bx, by;
        ax = a.x;
        ay = a.y;
        bx = b.x;
        by = b.y;
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic logic [23:0] widen_rgb(input logic [11:0] c);
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};
    endfunction

    task automatic report_value(input string name, input int expected, input int actual);
        value_errors++;
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic model_clear();
        for (int a = 0; a < N_PIX; a++) begin
            m_depth[a] = DEPTH_FAR;
            m_cidx[a]  = CIDX_W'(CLR_CIDX);
        end
    endtask

    // clipped box walk with either winding and a strict depth test
    task automatic model_draw(input triangle_t t);
        vertex_t v [3];
        int x0, x1, y0, y1, e0, e1, e2, a;
        v[0] = t.v0;
        v[1] = t.v1;
        v[2] = t.v2;
        x0 = v[0].x;
        x1 = v[0].x;
        y0 = v[0].y;
        y1 = v[0].y;
        for (int k = 1; k < 3; k++) begin
            if (v[k].x < x0) x0 = v[k].x;
            if (v[k].x > x1) x1 = v[k].x;
            if (v[k].y < y0) y0 = v[k].y;
            if (v[k].y > y1) y1 = v[k].y;
        end
        if (x0 < 0) x0 = 0;
        if (y0 < 0) y0 = 0;
        if (x1 > SW - 1) x1 = SW - 1;
        if (y1 > SH - 1) y1 = SH - 1;
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                e0 = edge_val(v[0], v[1], x, y);
                e1 = edge_val(v[1], v[2], x, y);
                e2 = edge_val(v[2], v[0], x, y);
                a  = y * SW + x;
                if (((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
                    && t.z < m_depth[a]) begin
                    m_depth[a] = t.z;
                    m_cidx[a]  = t.cidx;
                end
            end
        end
    endtask

    task automatic do_clear();
        int n;
        i_clear <= 1'b1;
        @(posedge clk_pix);
        i_clear <= 1'b0;
        n = 0;
        @(posedge clk_pix);
        while (o_clear_busy === 1'b1) begin
            n++;
            @(posedge clk_pix);
        end
        if (n != N_PIX) report_value("clear_length", N_PIX, n);
        model_clear();
    endtask

    // poke holds i_start one more cycle with another triangle while busy
    task automatic run_triangle(input triangle_t t, input bit in_video, input bit poke);
        if (in_video) begin
            @(posedge clk_pix);
            while (o_de !== 1'b1) @(posedge clk_pix);
        end
        i_tri   <= t;
        i_start <= 1'b1;
        @(posedge clk_pix);
        if (poke) i_tri <= random_tri();
        else i_start <= 1'b0;
        @(posedge clk_pix);
        i_start <= 1'b0;
        if (o_busy !== 1'b1) report_problem("o_busy did not rise after i_start");
        while (o_done !== 1'b1) @(posedge clk_pix);
        if (o_busy !== 1'b0) report_problem("o_busy still high together with o_done");
        model_draw(t);
    endtask

    task automatic check_frame(input string name);
        int de_cnt, frame_cnt, ex, ey;
        logic [23:0] exp_rgb;
        de_cnt = 0;
        frame_cnt = 0;
        ex = 0;
        ey = 0;
        @(posedge clk_pix);
        while (o_frame !== 1'b1) @(posedge clk_pix);
        for (int i = 0; i < HT * VT; i++) begin
            if (i != 0) @(posedge clk_pix);
            if (o_frame === 1'b1) begin
                frame_cnt++;
                if (!(o_de === 1'b1 && o_sx == 0 && o_sy == 0))
                    report_problem("o_frame pulsed away from pixel (0,0)");
            end
            if (o_de === 1'b1 && de_cnt < N_PIX) begin
                if (o_sx != ex) report_value("scan_x", ex, o_sx);
                if (o_sy != ey) report_value("scan_y", ey, o_sy);
                exp_rgb = widen_rgb(PALETTE[m_cidx[ey * SW + ex]]);
                if ({o_r, o_g, o_b} !== exp_rgb)
                    report_value($sformatf("%s (%0d,%0d)", name, ex, ey), exp_rgb,
                                 {o_r, o_g, o_b});
                ex++;
                if (ex == SW) begin
                    ex = 0;
                    ey++;
                end
            end
            if (o_de === 1'b1) de_cnt++;
        end
        if (de_cnt != N_PIX) report_value("scan_de_count", N_PIX, de_cnt);
        if (frame_cnt != 1) report_value("scan_frame_pulses", 1, frame_cnt);
    endtask

    initial begin
        triangle_t t;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_clear = 1'b0;
        i_tri   = '0;
        repeat (16) @(posedge clk_pix);
        i_rst_n <= 1'b1;
        @(posedge clk_pix);

        do_clear();
        check_frame("clear");

        t = random_tri();
        t.v1.x = COORD_W'(SW + 2);  // force clipping on the right edge
        run_triangle(t, 1'b0, 1'b0);
        check_frame("single");

        do_clear();
        repeat (12) begin
            t = random_tri();
            t.z = DEPTH_W'(rand_bits(2));  // few depth levels so equal z overlaps occur
            run_triangle(t, 1'b0, 1'b0);
        end
        check_frame("depth");

        repeat (4) run_triangle(random_tri(), 1'b1, 1'b1);
        check_frame("contention");

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== raster_top.f ====
source/raster_pkg.sv
source/tri_rasterizer.sv
source/fb_arbiter.sv
source/frame_buffer.sv
source/display_scan.sv
source/raster_top.sv
sim/raster_assert.sv
sim/tb_raster_top.sv

// ==== Makefile ====
# Verilator build and run for the triangle rasterizer testbench

VERILATOR  ?= verilator
TOP        ?= tb_raster_top
FILELIST   ?= raster_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
